/* src/bp_macros.svh */
/*
 * Build-time constants for the branch prediction front end.
 * BTB table size, address width and fetch reset address.
 */

`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// Number of BTB entries. Must be a power of two.
`define BP_ENTRIES 1024

// Width of fetch addresses and branch targets.
`define BP_XLEN 32

// First fetch address after reset.
`define BP_RESET_PC 32'h0000_0100

`endif

/* src/bp_pkg.sv */
/*
 * Shared types and helpers for the branch prediction front end.
 * 2-bit branch state, BTB address field widths,
 * saturating state update and taken decode.
 */

`include "bp_macros.svh"

package bp_pkg;

        // Two bit saturating branch state.
        typedef enum logic [1:0] {
                SNT = 2'b00,
                WNT = 2'b01,
                WT  = 2'b10,
                ST  = 2'b11
        } bp_state_t;

        // Address split is offset bit, index, then tag.
        localparam int BP_INDEX_W = $clog2(`BP_ENTRIES);
        localparam int BP_TAG_W   = `BP_XLEN - BP_INDEX_W - 1;

        // New state from the predicted state and the resolve outcome.
        function automatic bp_state_t bp_next_state(input bp_state_t state, input logic nok);
                bp_state_t nxt;

                nxt = state;
                if (nok)
                begin
                        // Mispredict moves one step toward the other direction.
                        case (state)
                                SNT:     nxt = WNT;
                                WNT:     nxt = WT;
                                WT:      nxt = WNT;
                                default: nxt = WT;
                        endcase
                end
                else
                begin
                        // Correct prediction saturates in the same direction.
                        nxt = (state == WT || state == ST) ? ST : SNT;
                end
                return nxt;
        endfunction

        // Predicted taken for both taken states.
        function automatic logic bp_is_taken(input bp_state_t state);
                return (state == WT) || (state == ST);
        endfunction

endpackage

/* src/bp_ram.sv */
/*
 * Simple dual port RAM.
 * One write port, one read port with a registered read and a read enable.
 * A read of an address written in the same cycle returns old data.
 */

`timescale 1ns/100ps

module bp_ram #(
        parameter int DEPTH = 1024,
        parameter int WIDTH = 32
) (
        input  logic                     i_clk,
        input  logic                     i_wr_en,
        input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
        input  logic [WIDTH-1:0]         i_wr_data,
        input  logic                     i_rd_en,
        input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
        output logic [WIDTH-1:0]         o_rd_data
);

        // Storage array.
        logic [WIDTH-1:0] mem [DEPTH];

        // Write port.
        always_ff @(posedge i_clk)
        begin
                if (i_wr_en)
                begin
                        mem[i_wr_addr] <= i_wr_data;
                end
        end

        // Read port, data holds while the enable is low.
        always_ff @(posedge i_clk)
        begin
                if (i_rd_en)
                begin
                        o_rd_data <= mem[i_rd_addr];
                end
        end

        // Writes must stay inside the array.
        a_wr_addr_range: assert property (@(posedge i_clk) i_wr_en |-> (i_wr_addr < DEPTH))
                else $error("RAM write address out of range.");

endmodule

/* src/bp_btb.sv */
/*
 * Direct mapped branch target buffer.
 * Feedback write path with state update and valid bits.
 * Stallable read path through the table RAM.
 * Tag check and registered redirect, two cycles after the fetch address.
 */

`timescale 1ns/100ps

`include "bp_macros.svh"

module bp_btb
        import bp_pkg::*;
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_stall,
        input  logic                i_clear,

        // Feedback from the resolve stage.
        input  logic                i_fb_ok,
        input  logic                i_fb_nok,
        input  logic [`BP_XLEN-1:0] i_fb_src_addr,
        input  bp_state_t           i_fb_state,
        input  logic [`BP_XLEN-1:0] i_fb_dest_addr,

        // Fetch addresses, current and previous.
        input  logic [`BP_XLEN-1:0] i_rd_addr,
        input  logic [`BP_XLEN-1:0] i_rd_addr_del,

        // Prediction out.
        output logic                o_redirect,
        output logic [`BP_XLEN-1:0] o_redirect_pc,
        output bp_state_t           o_branch_state
);

        // One table entry, target on top and state in the low bits.
        typedef struct packed {
                logic [`BP_XLEN-1:0] target;
                logic [BP_TAG_W-1:0] tag;
                bp_state_t           state;
        } btb_entry_t;

        localparam int ENTRY_W = $bits(btb_entry_t);

        logic [`BP_ENTRIES-1:0] valid;
        logic                   rd_valid;
        logic                   wr_en;
        logic                   rd_en;
        logic [BP_INDEX_W-1:0]  wr_index;
        logic [BP_INDEX_W-1:0]  rd_index;
        btb_entry_t             wr_entry;
        btb_entry_t             rd_entry;
        logic                   tag_match;
        logic                   hit;

        ////////////////////////////////
        // Write path
        ////////////////////////////////

        // Every feedback writes, ok or not-ok.
        assign wr_en    = i_fb_ok | i_fb_nok;
        assign wr_index = i_fb_src_addr[BP_INDEX_W:1];

        // Entry to store.
        // New state comes from the predicted state and the outcome.
        assign wr_entry.target = i_fb_dest_addr;
        assign wr_entry.tag    = i_fb_src_addr[`BP_XLEN-1:BP_INDEX_W+1];
        assign wr_entry.state  = bp_next_state(i_fb_state, i_fb_nok);

        // Valid bits.
        // Set on write, cleared on reset or invalidate.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        valid <= '0;
                end
                else if (wr_en)
                begin
                        valid[wr_index] <= 1'b1;
                end
        end

        ////////////////////////////////
        // Read path
        ////////////////////////////////

        // Read is frozen under stall.
        assign rd_en    = ~i_stall;
        assign rd_index = i_rd_addr[BP_INDEX_W:1];

        bp_ram #(
                .DEPTH (`BP_ENTRIES),
                .WIDTH (ENTRY_W)
        ) u_ram (
                .i_clk     (i_clk),
                .i_wr_en   (wr_en),
                .i_wr_addr (wr_index),
                .i_wr_data (wr_entry),
                .i_rd_en   (rd_en),
                .i_rd_addr (rd_index),
                .o_rd_data (rd_entry)
        );

        // Valid bit registered alongside the RAM read.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        rd_valid <= 1'b0;
                end
                else if (rd_en)
                begin
                        rd_valid <= valid[rd_index];
                end
        end

        ////////////////////////////////
        // Tag check
        ////////////////////////////////

        // Stored tag against the previous fetch address.
        assign tag_match = (rd_entry.tag == i_rd_addr_del[`BP_XLEN-1:BP_INDEX_W+1]);

        // Redirect only on a valid, matching, taken entry.
        assign hit = rd_valid & tag_match & bp_is_taken(rd_entry.state);

        // Redirect pulse and state.
        // Invalidate drops a pending redirect.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        o_redirect     <= 1'b0;
                        o_branch_state <= SNT;
                end
                else if (!i_stall)
                begin
                        o_redirect     <= hit;
                        o_branch_state <= rd_entry.state;
                end
        end

        // Target is loaded only with a hit.
        always_ff @(posedge i_clk)
        begin
                if (!i_stall && hit)
                begin
                        o_redirect_pc <= rd_entry.target;
                end
        end

        ////////////////////////////////
        // Checks
        ////////////////////////////////

        // Resolve never reports both outcomes for one branch.
        a_fb_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
                !(i_fb_ok && i_fb_nok))
                else $error("BTB feedback ok and not-ok together.");

        // Branch sources sit on halfword boundaries.
        a_fb_align: assert property (@(posedge i_clk) disable iff (i_reset)
                wr_en |-> !i_fb_src_addr[0])
                else $error("BTB feedback source not halfword aligned.");

endmodule

/* src/bp_fetch_pc.sv */
/*
 * Fetch program counter.
 * Redirect priority, stall hold with redirect capture,
 * and the delayed fetch address for the BTB tag check.
 */

`timescale 1ns/100ps

`include "bp_macros.svh"

module bp_fetch_pc (
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_stall,
        input  logic                i_btb_redirect,
        input  logic [`BP_XLEN-1:0] i_btb_pc,
        input  logic                i_rs_redirect,
        input  logic [`BP_XLEN-1:0] i_rs_pc,
        output logic [`BP_XLEN-1:0] o_fetch_pc,
        output logic [`BP_XLEN-1:0] o_fetch_pc_del
);

        logic                pend_rs;
        logic                pend_btb;
        logic [`BP_XLEN-1:0] pend_rs_pc;
        logic [`BP_XLEN-1:0] pend_btb_pc;
        logic                take_rs;
        logic                take_btb;
        logic [`BP_XLEN-1:0] rs_pc;
        logic [`BP_XLEN-1:0] btb_pc;
        logic [`BP_XLEN-1:0] next_pc;

        // Live redirect wins over a captured one.
        assign take_rs  = i_rs_redirect | pend_rs;
        assign take_btb = i_btb_redirect | pend_btb;
        assign rs_pc    = i_rs_redirect ? i_rs_pc : pend_rs_pc;
        assign btb_pc   = i_btb_redirect ? i_btb_pc : pend_btb_pc;

        // Mispredict first, then prediction, then sequential.
        assign next_pc = take_rs  ? rs_pc  :
                         take_btb ? btb_pc :
                         o_fetch_pc + `BP_XLEN'd4;

        // Redirects seen during a stall.
        // Cleared by the first cycle that moves fetch.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || !i_stall)
                begin
                        pend_rs  <= 1'b0;
                        pend_btb <= 1'b0;
                end
                else
                begin
                        pend_rs  <= pend_rs | i_rs_redirect;
                        pend_btb <= pend_btb | i_btb_redirect;
                end
        end

        // Latest address seen during the stall is kept.
        always_ff @(posedge i_clk)
        begin
                if (i_stall && i_rs_redirect)
                begin
                        pend_rs_pc <= i_rs_pc;
                end
                if (i_stall && i_btb_redirect)
                begin
                        pend_btb_pc <= i_btb_pc;
                end
        end

        // Counter and its copy from the last moving cycle.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_fetch_pc     <= `BP_RESET_PC;
                        o_fetch_pc_del <= `BP_RESET_PC;
                end
                else if (!i_stall)
                begin
                        o_fetch_pc     <= next_pc;
                        o_fetch_pc_del <= o_fetch_pc;
                end
        end

endmodule

/* src/bp_resolve.sv */
/*
 * Branch resolve stage.
 * Compares predicted and actual direction of resolved branches,
 * produces ok / not-ok BTB feedback and mispredict fetch redirects.
 */

`timescale 1ns/100ps

`include "bp_macros.svh"

module bp_resolve
        import bp_pkg::*;
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_stall,

        // Resolved branch.
        input  logic                i_br_valid,
        input  logic [`BP_XLEN-1:0] i_br_src_pc,
        input  logic                i_br_taken,
        input  logic [`BP_XLEN-1:0] i_br_target,
        input  bp_state_t           i_br_pred_state,

        // BTB feedback.
        output logic                o_fb_ok,
        output logic                o_fb_nok,
        output logic [`BP_XLEN-1:0] o_fb_src,
        output bp_state_t           o_fb_state,
        output logic [`BP_XLEN-1:0] o_fb_dest,

        // Fetch redirect on mispredict.
        output logic                o_redirect,
        output logic [`BP_XLEN-1:0] o_redirect_pc
);

        logic                mispredict;
        logic [`BP_XLEN-1:0] fix_pc;

        // Direction check against the predicted state.
        assign mispredict = i_br_valid & (bp_is_taken(i_br_pred_state) != i_br_taken);

        // Correct path. Target if taken, else the next sequential fetch.
        assign fix_pc = i_br_taken ? i_br_target : i_br_src_pc + `BP_XLEN'd4;

        // Feedback pulses, not stalled.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_fb_ok  <= 1'b0;
                        o_fb_nok <= 1'b0;
                end
                else
                begin
                        o_fb_ok  <= i_br_valid & ~mispredict;
                        o_fb_nok <= mispredict;
                end
        end

        // Feedback payload.
        always_ff @(posedge i_clk)
        begin
                if (i_br_valid)
                begin
                        o_fb_src   <= i_br_src_pc;
                        o_fb_state <= i_br_pred_state;
                        o_fb_dest  <= i_br_target;
                end
        end

        // Redirect pulse.
        // Held under stall, a new mispredict still sets it.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_redirect <= 1'b0;
                end
                else if (!i_stall)
                begin
                        o_redirect <= mispredict;
                end
                else if (mispredict)
                begin
                        o_redirect <= 1'b1;
                end
        end

        // Newest mispredict address.
        always_ff @(posedge i_clk)
        begin
                if (mispredict)
                begin
                        o_redirect_pc <= fix_pc;
                end
        end

endmodule

/* src/bp_top.sv */
/*
 * Fetch front end top level.
 * Fetch counter, branch resolve stage and BTB.
 */

`timescale 1ns/100ps

`include "bp_macros.svh"

module bp_top
        import bp_pkg::*;
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_stall,
        input  logic                i_invalidate,

        // Resolved branch from the back end.
        input  logic                i_br_valid,
        input  logic [`BP_XLEN-1:0] i_br_src_pc,
        input  logic                i_br_taken,
        input  logic [`BP_XLEN-1:0] i_br_target,
        input  bp_state_t           i_br_pred_state,

        // Fetch and prediction.
        output logic [`BP_XLEN-1:0] o_fetch_pc,
        output bp_state_t           o_pred_state,
        output logic                o_btb_redirect,
        output logic [`BP_XLEN-1:0] o_btb_target,
        output logic                o_rs_redirect,
        output logic [`BP_XLEN-1:0] o_rs_pc
);

        logic [`BP_XLEN-1:0] fetch_pc_del;
        logic                fb_ok;
        logic                fb_nok;
        logic [`BP_XLEN-1:0] fb_src;
        bp_state_t           fb_state;
        logic [`BP_XLEN-1:0] fb_dest;

        ////////////////////////////////
        // Fetch
        ////////////////////////////////

        bp_fetch_pc u_fetch_pc (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_stall        (i_stall),
                .i_btb_redirect (o_btb_redirect),
                .i_btb_pc       (o_btb_target),
                .i_rs_redirect  (o_rs_redirect),
                .i_rs_pc        (o_rs_pc),
                .o_fetch_pc     (o_fetch_pc),
                .o_fetch_pc_del (fetch_pc_del)
        );

        ////////////////////////////////
        // Resolve and predict
        ////////////////////////////////

        bp_resolve u_resolve (
                .i_clk           (i_clk),
                .i_reset         (i_reset),
                .i_stall         (i_stall),
                .i_br_valid      (i_br_valid),
                .i_br_src_pc     (i_br_src_pc),
                .i_br_taken      (i_br_taken),
                .i_br_target     (i_br_target),
                .i_br_pred_state (i_br_pred_state),
                .o_fb_ok         (fb_ok),
                .o_fb_nok        (fb_nok),
                .o_fb_src        (fb_src),
                .o_fb_state      (fb_state),
                .o_fb_dest       (fb_dest),
                .o_redirect      (o_rs_redirect),
                .o_redirect_pc   (o_rs_pc)
        );

        // Invalidate empties the table.
        bp_btb u_btb (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_stall        (i_stall),
                .i_clear        (i_invalidate),
                .i_fb_ok        (fb_ok),
                .i_fb_nok       (fb_nok),
                .i_fb_src_addr  (fb_src),
                .i_fb_state     (fb_state),
                .i_fb_dest_addr (fb_dest),
                .i_rd_addr      (o_fetch_pc),
                .i_rd_addr_del  (fetch_pc_del),
                .o_redirect     (o_btb_redirect),
                .o_redirect_pc  (o_btb_target),
                .o_branch_state (o_pred_state)
        );

endmodule

/* testbench/bp_clock_gen.sv */
/*
 * Free running testbench clock.
 * Starts low, toggles every half period.
 */

`timescale 1ns/100ps

module bp_clock_gen #(
        parameter int PERIOD_NS = 100
) (
        output logic o_clk
);

        // Start low so the first rising edge is half a period in.
        initial
        begin
                o_clk = 1'b0;
        end

        always
        begin
                #(PERIOD_NS / 2) o_clk = ~o_clk;
        end

endmodule

/* testbench/bp_tb.sv */
/*
 * Directed testbench for the fetch front end.
 * Reference model of the BTB table, resolve and fetch steering tasks,
 * five directed tests, a cycle limit and a closing summary.
 */

`timescale 1ns/100ps

`include "bp_macros.svh"

module bp_tb
        import bp_pkg::*;
;

        // Tests use under 300 cycles, so ten times that is plenty.
        localparam int MAX_CYCLES = 3000;

        logic                i_clk;
        logic                i_reset;
        logic                i_stall;
        logic                i_invalidate;
        logic                i_br_valid;
        logic [`BP_XLEN-1:0] i_br_src_pc;
        logic                i_br_taken;
        logic [`BP_XLEN-1:0] i_br_target;
        bp_state_t           i_br_pred_state;
        logic [`BP_XLEN-1:0] o_fetch_pc;
        bp_state_t           o_pred_state;
        logic                o_btb_redirect;
        logic [`BP_XLEN-1:0] o_btb_target;
        logic                o_rs_redirect;
        logic [`BP_XLEN-1:0] o_rs_pc;

        // Reference copy of the table, one slot per index.
        logic                ref_valid   [`BP_ENTRIES];
        logic                ref_written [`BP_ENTRIES];
        logic [BP_TAG_W-1:0] ref_tag     [`BP_ENTRIES];
        logic [`BP_XLEN-1:0] ref_target  [`BP_ENTRIES];
        bp_state_t           ref_state   [`BP_ENTRIES];

        int error_count = 0;
        int check_count = 0;
        int tests_run   = 0;
        int cycle_count = 0;

        bp_clock_gen #(.PERIOD_NS (100)) u_clock_gen (.o_clk (i_clk));

        bp_top uut (
                .i_clk           (i_clk),
                .i_reset         (i_reset),
                .i_stall         (i_stall),
                .i_invalidate    (i_invalidate),
                .i_br_valid      (i_br_valid),
                .i_br_src_pc     (i_br_src_pc),
                .i_br_taken      (i_br_taken),
                .i_br_target     (i_br_target),
                .i_br_pred_state (i_br_pred_state),
                .o_fetch_pc      (o_fetch_pc),
                .o_pred_state    (o_pred_state),
                .o_btb_redirect  (o_btb_redirect),
                .o_btb_target    (o_btb_target),
                .o_rs_redirect   (o_rs_redirect),
                .o_rs_pc         (o_rs_pc)
        );

        // Run limit.
        always @(posedge i_clk)
        begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= MAX_CYCLES)
                begin
                        $display("Timeout: the tests did not complete within %0d cycles.",
                                 MAX_CYCLES);
                        $display("Finished with errors");
                        $finish;
                end
        end

        //////////////////////////////
        // Model helpers
        //////////////////////////////

        function automatic int index_of(input logic [`BP_XLEN-1:0] addr);
                return int'(addr[BP_INDEX_W:1]);
        endfunction

        function automatic logic [BP_TAG_W-1:0] tag_of(input logic [`BP_XLEN-1:0] addr);
                return addr[`BP_XLEN-1:BP_INDEX_W+1];
        endfunction

        // Any halfword aligned address.
        function automatic logic [`BP_XLEN-1:0] random_addr();
                return $urandom & 32'hffff_fffe;
        endfunction

        // Upper half of the counter predicts taken.
        function automatic logic predicts_taken(input bp_state_t state);
                return state[1];
        endfunction

        // Counter step. A miss moves toward the other side, a hit saturates.
        function automatic bp_state_t expected_state(input bp_state_t pred, input logic nok);
                if (!nok)
                begin
                        return predicts_taken(pred) ? ST : SNT;
                end
                case (pred)
                        SNT:     return WNT;
                        WNT:     return WT;
                        WT:      return WNT;
                        default: return WT;
                endcase
        endfunction

        task automatic model_update(input logic [`BP_XLEN-1:0] src, input logic nok,
                                    input logic [`BP_XLEN-1:0] target, input bp_state_t pred);
                int idx;

                idx              = index_of(src);
                ref_valid[idx]   = 1'b1;
                ref_written[idx] = 1'b1;
                ref_tag[idx]     = tag_of(src);
                ref_target[idx]  = target;
                ref_state[idx]   = expected_state(pred, nok);
        endtask

        //////////////////////////////
        // Drive and check
        //////////////////////////////

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                check_count++;
                assert (got === exp)
                else
                begin
                        $display("[ERROR] %s: expected %h, got %h", name, exp, got);
                        error_count++;
                end
        endtask

        // One resolved branch. Sampled one cycle after the strobe.
        task automatic resolve_branch(input logic [`BP_XLEN-1:0] src, input logic taken,
                                      input logic [`BP_XLEN-1:0] target, input bp_state_t pred);
                logic                nok;
                logic [`BP_XLEN-1:0] fix_pc;

                nok    = (predicts_taken(pred) != taken);
                fix_pc = taken ? target : src + 32'd4;
                @(posedge i_clk);
                i_br_valid      <= 1'b1;
                i_br_src_pc     <= src;
                i_br_taken      <= taken;
                i_br_target     <= target;
                i_br_pred_state <= pred;
                @(posedge i_clk);
                i_br_valid <= 1'b0;
                @(negedge i_clk);
                check_value("o_rs_redirect", o_rs_redirect, nok);
                if (nok)
                begin
                        check_value("o_rs_pc", o_rs_pc, fix_pc);
                end
                model_update(src, nok, target, pred);
        endtask

        // Steers fetch to addr with a not-taken mispredict at addr - 4,
        // then follows addr through the BTB for four cycles.
        task automatic fetch_at(input logic [`BP_XLEN-1:0] addr);
                int  idx;
                logic hit;

                resolve_branch(addr - 32'd4, 1'b0, random_addr(), WT);
                idx = index_of(addr);
                hit = ref_valid[idx] && (ref_tag[idx] == tag_of(addr)) &&
                      predicts_taken(ref_state[idx]);
                @(negedge i_clk);
                check_value("o_fetch_pc", o_fetch_pc, addr);
                @(negedge i_clk);
                check_value("o_fetch_pc", o_fetch_pc, addr + 32'd4);
                // Prediction for addr lands two cycles after it was fetched.
                @(negedge i_clk);
                check_value("o_fetch_pc", o_fetch_pc, addr + 32'd8);
                check_value("o_btb_redirect", o_btb_redirect, hit);
                if (ref_written[idx])
                begin
                        check_value("o_pred_state", o_pred_state, ref_state[idx]);
                end
                if (hit)
                begin
                        check_value("o_btb_target", o_btb_target, ref_target[idx]);
                end
                @(negedge i_clk);
                check_value("o_fetch_pc", o_fetch_pc, hit ? ref_target[idx] : addr + 32'd12);
        endtask

        task automatic invalidate_table();
                int k;

                @(posedge i_clk);
                i_invalidate <= 1'b1;
                @(posedge i_clk);
                i_invalidate <= 1'b0;
                for (k = 0; k < `BP_ENTRIES; k++)
                begin
                        ref_valid[k] = 1'b0;
                end
        endtask

        task automatic check_hold(input logic [31:0] pc, input logic redirect,
                                  input logic [31:0] target, input bp_state_t state);
                check_value("o_fetch_pc", o_fetch_pc, pc);
                check_value("o_btb_redirect", o_btb_redirect, redirect);
                check_value("o_btb_target", o_btb_target, target);
                check_value("o_pred_state", o_pred_state, state);
        endtask

        //////////////////////////////
        // Tests
        //////////////////////////////

        task automatic test_reset_fetch();
                logic [`BP_XLEN-1:0] exp_pc;
                int                  k;

                exp_pc = `BP_RESET_PC;
                @(negedge i_clk);
                check_value("o_fetch_pc", o_fetch_pc, exp_pc);
                check_value("o_rs_redirect", o_rs_redirect, 1'b0);
                check_value("o_btb_redirect", o_btb_redirect, 1'b0);
                for (k = 0; k < 16; k++)
                begin
                        exp_pc = exp_pc + 32'd4;
                        @(negedge i_clk);
                        check_value("o_fetch_pc", o_fetch_pc, exp_pc);
                        check_value("o_btb_redirect", o_btb_redirect, 1'b0);
                end
        endtask

        task automatic test_train_predict();
                logic [`BP_XLEN-1:0] addr;
                logic [`BP_XLEN-1:0] target;

                addr   = random_addr();
                target = random_addr();
                // Taken against a WNT guess is a miss and leaves WT.
                resolve_branch(addr, 1'b1, target, WNT);
                fetch_at(addr);
        endtask

        task automatic test_counter_sequence();
                logic [`BP_XLEN-1:0] addr;
                logic [`BP_XLEN-1:0] target;
                logic [7:0]          outcome;
                bp_state_t           pred;
                int                  k;

                addr    = random_addr();
                target  = random_addr();
                // LSB first. Climbs to ST, falls to SNT, steps up once more.
                outcome = 8'b1000_1111;
                pred    = SNT;
                for (k = 0; k < 8; k++)
                begin
                        resolve_branch(addr, outcome[k], target, pred);
                        fetch_at(addr);
                        pred = ref_state[index_of(addr)];
                end
        endtask

        task automatic test_alias_invalidate();
                logic [`BP_XLEN-1:0] addr;
                logic [`BP_XLEN-1:0] target;

                addr   = random_addr();
                target = random_addr();
                resolve_branch(addr, 1'b1, target, WT);
                fetch_at(addr);
                // Bit 20 sits in the tag, so same index, other tag.
                fetch_at(addr ^ 32'h0010_0000);
                invalidate_table();
                fetch_at(addr);
                resolve_branch(addr, 1'b1, target, ST);
                fetch_at(addr);
        endtask

        task automatic test_stall();
                logic [`BP_XLEN-1:0] held_pc;
                logic [`BP_XLEN-1:0] held_target;
                logic [`BP_XLEN-1:0] br_addr;
                logic [`BP_XLEN-1:0] br_target;
                logic                held_redirect;
                bp_state_t           held_state;

                br_addr   = random_addr();
                br_target = random_addr();
                @(posedge i_clk);
                i_stall <= 1'b1;
                @(negedge i_clk);
                held_pc       = o_fetch_pc;
                held_redirect = o_btb_redirect;
                held_target   = o_btb_target;
                held_state    = o_pred_state;
                repeat (3)
                begin
                        @(negedge i_clk);
                        check_hold(held_pc, held_redirect, held_target, held_state);
                end
                // Miss under stall. Table write goes ahead, redirect waits.
                resolve_branch(br_addr, 1'b1, br_target, WNT);
                repeat (3)
                begin
                        @(negedge i_clk);
                        check_hold(held_pc, held_redirect, held_target, held_state);
                        check_value("o_rs_redirect", o_rs_redirect, 1'b1);
                end
                @(posedge i_clk);
                i_stall <= 1'b0;
                @(negedge i_clk);
                check_value("o_fetch_pc", o_fetch_pc, held_pc);
                @(negedge i_clk);
                check_value("o_fetch_pc", o_fetch_pc, br_target);
                fetch_at(br_addr);
        endtask

        task automatic report_test(input string name, input int errors_before);
                tests_run++;
                $display("Test %0d, %s: %0d errors", tests_run, name,
                         error_count - errors_before);
        endtask

        //////////////////////////////
        // Sequence
        //////////////////////////////

        initial
        begin
                int errs;
                int k;

                i_reset         = 1'b1;
                i_stall         = 1'b0;
                i_invalidate    = 1'b0;
                i_br_valid      = 1'b0;
                i_br_src_pc     = '0;
                i_br_taken      = 1'b0;
                i_br_target     = '0;
                i_br_pred_state = SNT;
                for (k = 0; k < `BP_ENTRIES; k++)
                begin
                        ref_valid[k]   = 1'b0;
                        ref_written[k] = 1'b0;
                end
                void'($urandom(32'h87e7_a280));

                repeat (10) @(posedge i_clk);
                i_reset <= 1'b0;

                errs = error_count;
                test_reset_fetch();
                report_test("reset and sequential fetch", errs);
                errs = error_count;
                test_train_predict();
                report_test("train and predict", errs);
                errs = error_count;
                test_counter_sequence();
                report_test("counter sequence", errs);
                errs = error_count;
                test_alias_invalidate();
                report_test("aliasing and invalidate", errs);
                errs = error_count;
                test_stall();
                report_test("stall", errs);

                $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, check_count,
                         error_count);
                if (error_count == 0)
                begin
                        $display("Finished with no errors");
                end
                else
                begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

/* bp_fetch.f */
+incdir+src
src/bp_pkg.sv
src/bp_ram.sv
src/bp_btb.sv
src/bp_fetch_pc.sv
src/bp_resolve.sv
src/bp_top.sv
testbench/bp_clock_gen.sv
testbench/bp_tb.sv
